/* Makefile */
# Verilator flow for the cache testbench

TOP := cache_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --top-module $(TOP) -f build.f

sim:
	verilator --binary --timing --top-module $(TOP) -f build.f -o $(TOP)
	./obj_dir/$(TOP) 2>&1 | tee sim.log
	grep -q "Simulation finished: PASS" sim.log

clean:
	rm -rf obj_dir sim.log

/* bench/axi_mem_model.sv */
`timescale 1ns/1ps

module axi_mem_model (
    input  logic         clk,
    input  logic         rd_req,
    input  logic [31:0]  rd_addr,
    output logic         rd_rdy,
    output logic         ret_valid,
    output logic         ret_last,
    output logic [31:0]  ret_data,
    input  logic         wr_req,
    input  logic [31:0]  wr_addr,
    input  logic [127:0] wr_data,
    output logic         wr_rdy,
    output int           rd_count,
    output int           wr_count,
    output logic [31:0]  last_rd_addr,
    output logic [31:0]  last_wr_addr,
    output logic [127:0] last_wr_data
);

    logic [31:0] mem [logic [31:0]];   // only words written back
    logic [15:0] lfsr;

    // x^16 + x^14 + x^13 + x^11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic logic [31:0] read_word(input logic [31:0] a);
        if (mem.exists(a))
            return mem[a];
        return a ^ 32'hA5A5_0000;
    endfunction

    // 0 to 3 cycles, two lfsr bits
    task automatic ready_delay();
        int d;
        d = 0;
        for (int i = 0; i < 2; i++) begin
            lfsr = lfsr_next(lfsr);
            d    = 2 * d + int'(lfsr[0]);
        end
        repeat (d) begin
            @(posedge clk);
            #1;
        end
    endtask

    initial begin
        lfsr         = 16'd17857;
        rd_rdy       = 1'b0;
        wr_rdy       = 1'b0;
        ret_valid    = 1'b0;
        ret_last     = 1'b0;
        ret_data     = '0;
        rd_count     = 0;
        wr_count     = 0;
        last_rd_addr = '0;
        last_wr_addr = '0;
        last_wr_data = '0;
        forever begin
            @(posedge clk);
            #1;
            if (wr_req) begin
                ready_delay();
                wr_rdy       = 1'b1;
                last_wr_addr = wr_addr;   // held until the handshake
                last_wr_data = wr_data;
                @(posedge clk);
                #1;
                wr_rdy = 1'b0;
                for (int w = 0; w < 4; w++)
                    mem[last_wr_addr + 32'(4 * w)] = last_wr_data[32*w +: 32];
                wr_count++;
            end else if (rd_req) begin
                ready_delay();
                rd_rdy       = 1'b1;
                last_rd_addr = rd_addr;
                rd_count++;
                @(posedge clk);
                #1;
                rd_rdy = 1'b0;
                for (int w = 0; w < 4; w++) begin
                    ret_valid = 1'b1;
                    ret_last  = (w == 3);
                    ret_data  = read_word(last_rd_addr + 32'(4 * w));
                    @(posedge clk);
                    #1;
                end
                ret_valid = 1'b0;
                ret_last  = 1'b0;
            end
        end
    end

endmodule

/* bench/cache_tb.sv */
`timescale 1ns/1ps

module cache_tb;

    localparam int NUM_TESTS = 5;
    localparam int CYCLE_NS  = 40;
    localparam int WAIT_MAX  = 100;   // cycles for one handshake

    logic                           clk, resetn;
    logic                           valid, op;
    logic [cache_pkg::INDEX_W-1:0]  index;
    logic [cache_pkg::TAG_W-1:0]    tag;
    logic [cache_pkg::OFFSET_W-1:0] offset;
    logic [cache_pkg::STRB_W-1:0]   wstrb, wr_wstrb;
    logic [cache_pkg::WORD_W-1:0]   wdata, rdata, ret_data;
    logic                           addr_ok, data_ok, rd_req, wr_req;
    logic                           rd_rdy, ret_valid, ret_last, wr_rdy;
    logic [2:0]                     rd_type, wr_type;
    logic [31:0]                    rd_addr, wr_addr, last_rd_addr, last_wr_addr;
    logic [cache_pkg::LINE_W-1:0]   wr_data, last_wr_data;
    int                             rd_count, wr_count;
    int                             taken;

    // reference model of the tag side
    logic [cache_pkg::SETS-1:0]     ref_valid [cache_pkg::WAYS];
    logic [cache_pkg::SETS-1:0]     ref_dirty [cache_pkg::WAYS];
    logic [cache_pkg::SETS-1:0]     ref_lru;   // way used last
    logic [cache_pkg::TAG_W-1:0]    ref_tag [cache_pkg::WAYS][cache_pkg::SETS];
    logic [31:0]                    shadow [logic [31:0]];   // words the CPU wrote
    logic [cache_pkg::WORD_W-1:0]   got [$];

    logic                           exp_miss, exp_wb;
    logic [31:0]                    exp_wb_addr;
    logic [cache_pkg::LINE_W-1:0]   exp_wb_line;

    tb_clock u_clock (.clk, .resetn);

    cache dut (
        .clk, .resetn, .valid, .op, .index, .tag, .offset, .wstrb, .wdata,
        .addr_ok, .data_ok, .rdata, .rd_req, .rd_type, .rd_addr, .rd_rdy,
        .ret_valid, .ret_last, .ret_data, .wr_req, .wr_type, .wr_addr,
        .wr_wstrb, .wr_data, .wr_rdy
    );

    axi_mem_model u_mem (
        .clk, .rd_req, .rd_addr, .rd_rdy, .ret_valid, .ret_last, .ret_data,
        .wr_req, .wr_addr, .wr_data, .wr_rdy, .rd_count, .wr_count,
        .last_rd_addr, .last_wr_addr, .last_wr_data
    );

    always @(negedge clk) begin
        if (resetn && data_ok)
            got.push_back(rdata);
    end

    task automatic stop_run();
        $display("Simulation finished: FAIL");
        $fatal(1);
    endtask

    task automatic check_word(input string name, input logic [cache_pkg::WORD_W-1:0] got_v,
                              input logic [cache_pkg::WORD_W-1:0] exp_v);
        if (got_v !== exp_v) begin
            $display("MISMATCH %s: got %h, expected %h", name, got_v, exp_v);
            stop_run();
        end
    endtask

    task automatic check_line(input string name, input logic [cache_pkg::LINE_W-1:0] got_v,
                              input logic [cache_pkg::LINE_W-1:0] exp_v);
        if (got_v !== exp_v) begin
            $display("MISMATCH %s: got %h, expected %h", name, got_v, exp_v);
            stop_run();
        end
    endtask

    task automatic check_addr(input string name, input logic [31:0] got_v,
                              input logic [31:0] exp_v);
        if (got_v !== exp_v) begin
            $display("MISMATCH %s: got %h, expected %h", name, got_v, exp_v);
            stop_run();
        end
    endtask

    task automatic check_type(input string name, input logic [2:0] got_v,
                              input logic [2:0] exp_v);
        if (got_v !== exp_v) begin
            $display("MISMATCH %s: got %h, expected %h", name, got_v, exp_v);
            stop_run();
        end
    endtask

    task automatic check_strb(input string name, input logic [cache_pkg::STRB_W-1:0] got_v,
                              input logic [cache_pkg::STRB_W-1:0] exp_v);
        if (got_v !== exp_v) begin
            $display("MISMATCH %s: got %h, expected %h", name, got_v, exp_v);
            stop_run();
        end
    endtask

    task automatic check_bit(input string name, input logic got_v, input logic exp_v);
        if (got_v !== exp_v) begin
            $display("MISMATCH %s: got %h, expected %h", name, got_v, exp_v);
            stop_run();
        end
    endtask

    function automatic logic [31:0] expected_word(input logic [31:0] a);
        if (shadow.exists(a))
            return shadow[a];
        return a ^ 32'hA5A5_0000;   // memory pattern
    endfunction

    task automatic merge_store(input logic [31:0] a, input logic [3:0] strb,
                               input logic [31:0] data);
        logic [31:0] w;
        w = expected_word(a);
        for (int k = 0; k < 4; k++)
            if (strb[k])
                w[8*k +: 8] = data[8*k +: 8];
        shadow[a] = w;
    endtask

    // hit or victim choice, then the LRU and dirty updates
    task automatic model_access(input logic wr, input logic [31:0] a);
        logic [cache_pkg::INDEX_W-1:0] idx;
        logic [cache_pkg::TAG_W-1:0]   tg;
        logic [1:0]                    hits;
        logic                          way;
        idx      = a[11:4];
        tg       = a[31:12];
        hits[0]  = ref_valid[0][idx] && (ref_tag[0][idx] == tg);
        hits[1]  = ref_valid[1][idx] && (ref_tag[1][idx] == tg);
        exp_miss = (hits == 2'b00);
        exp_wb   = 1'b0;
        if (!exp_miss) begin
            way = hits[1];
            ref_dirty[way][idx] = ref_dirty[way][idx] | wr;
        end else begin
            if (!ref_valid[0][idx])
                way = 1'b0;
            else if (!ref_valid[1][idx])
                way = 1'b1;
            else
                way = !ref_lru[idx];
            exp_wb      = ref_valid[way][idx] && ref_dirty[way][idx];
            exp_wb_addr = {ref_tag[way][idx], idx, 4'h0};
            for (int w = 0; w < 4; w++)
                exp_wb_line[32*w +: 32] = expected_word(exp_wb_addr + 32'(4 * w));
            ref_valid[way][idx] = 1'b1;
            ref_dirty[way][idx] = wr;
            ref_tag[way][idx]   = tg;
        end
        ref_lru[idx] = way;
    endtask

    // starts at 1 ns after an edge, returns 1 ns after the accepting edge
    task automatic send_request(input logic wr, input logic [31:0] a, input logic [3:0] strb,
                                input logic [31:0] data, output int waited);
        valid  = 1'b1;
        op     = wr;
        tag    = a[31:12];
        index  = a[11:4];
        offset = a[3:0];
        wstrb  = strb;
        wdata  = data;
        waited = 0;
        @(negedge clk);
        while (!addr_ok) begin
            waited++;
            if (waited > WAIT_MAX) begin
                $display("request to address %h was never accepted", a);
                stop_run();
            end
            @(negedge clk);
        end
        @(posedge clk);
        #1;
        valid = 1'b0;
    endtask

    task automatic take_response(output logic [31:0] word);
        int n;
        n = 0;
        while (got.size() <= taken) begin
            n++;
            if (n > WAIT_MAX) begin
                $display("no data_ok came back for an accepted request");
                stop_run();
            end
            @(posedge clk);
            #1;
        end
        word = got[taken];
        taken++;
    endtask

    task automatic wait_idle();
        int n;
        n = 0;
        @(negedge clk);
        while (!addr_ok) begin
            n++;
            if (n > WAIT_MAX) begin
                $display("cache did not return to idle");
                stop_run();
            end
            @(negedge clk);
        end
        @(posedge clk);
        #1;
    endtask

    task automatic access(input logic wr, input logic [31:0] a, input logic [3:0] strb,
                          input logic [31:0] data, input logic check_pause);
        int          rd_base;
        int          wr_base;
        int          waited;
        logic [31:0] word;
        rd_base = rd_count;
        wr_base = wr_count;
        model_access(wr, a);
        if (wr)
            merge_store(a, strb, data);
        send_request(wr, a, strb, data, waited);
        if (check_pause) begin
            @(negedge clk);   // lookup of the store
            check_bit("addr_ok", addr_ok, 1'b0);
            @(negedge clk);   // buffer write
            check_bit("addr_ok", addr_ok, 1'b0);
            @(negedge clk);
            check_bit("addr_ok", addr_ok, 1'b1);
            @(posedge clk);
            #1;
        end
        take_response(word);
        if (!wr)
            check_word("rdata", word, expected_word(a));
        wait_idle();
        check_bit("rd_req", rd_count != rd_base, exp_miss);
        if (exp_miss)
            check_addr("rd_addr", last_rd_addr, {a[31:4], 4'h0});
        check_bit("wr_req", wr_count != wr_base, exp_wb);
        if (exp_wb) begin
            check_addr("wr_addr", last_wr_addr, exp_wb_addr);
            check_line("wr_data", last_wr_data, exp_wb_line);
        end
    endtask

    task automatic load(input logic [31:0] a);
        access(1'b0, a, 4'h0, 32'h0, 1'b0);
    endtask

    task automatic test_reset_and_read();
        @(negedge clk);
        check_bit("addr_ok", addr_ok, 1'b1);
        check_bit("rd_req", rd_req, 1'b0);
        check_bit("wr_req", wr_req, 1'b0);
        check_bit("data_ok", data_ok, 1'b0);
        check_type("rd_type", rd_type, 3'h4);   // whole-line transfer
        check_type("wr_type", wr_type, 3'h4);
        check_strb("wr_wstrb", wr_wstrb, 4'hF);
        @(posedge clk);
        #1;
        load(32'h0001_2344);   // cold miss
        load(32'h0001_2348);   // same line, hit
    endtask

    task automatic test_write_hit();
        load(32'h0003_4560);
        access(1'b1, 32'h0003_4564, 4'b0110, 32'h1122_3344, 1'b1);
        load(32'h0003_4564);
    endtask

    task automatic test_write_miss();
        access(1'b1, 32'h0005_67A8, 4'b1001, 32'hDEAD_BEEF, 1'b0);
        for (int w = 0; w < 4; w++)
            load(32'h0005_67A0 + 32'(4 * w));
    endtask

    task automatic test_dirty_eviction();
        int wr_before;
        load(32'h0010_03C0);                                          // way 0
        access(1'b1, 32'h0010_03C8, 4'b1111, 32'hCAFE_F00D, 1'b0);   // now dirty
        load(32'h0020_03C4);                                          // way 1
        load(32'h0020_03C0);                                          // touch way 1
        load(32'h0030_03CC);   // evicts the dirty way 0
        check_addr("wr_addr", last_wr_addr, 32'h0010_03C0);
        wr_before = wr_count;
        load(32'h0010_03C8);   // clean victim this time
        check_bit("wr_req", wr_count != wr_before, 1'b0);
    endtask

    task automatic test_pipelined_reads();
        logic [31:0] addrs [5];
        logic [31:0] word;
        int          waited;
        int          rd_base;
        addrs   = '{32'h0001_2340, 32'h0003_456C, 32'h0005_67A4, 32'h0030_03C8, 32'h0010_03C8};
        rd_base = rd_count;
        foreach (addrs[i]) begin
            model_access(1'b0, addrs[i]);
            send_request(1'b0, addrs[i], 4'h0, 32'h0, waited);
            if (i > 0)
                check_bit("addr_ok in lookup", waited == 0, 1'b1);
        end
        foreach (addrs[i]) begin
            take_response(word);
            check_word("rdata", word, expected_word(addrs[i]));
        end
        wait_idle();
        check_bit("data_ok count", got.size() == taken, 1'b1);
        check_bit("rd_req", rd_count != rd_base, 1'b0);
    endtask

    initial begin
        valid     = 1'b0;
        op        = 1'b0;
        index     = '0;
        tag       = '0;
        offset    = '0;
        wstrb     = '0;
        wdata     = '0;
        taken     = 0;
        ref_lru   = '0;
        for (int w = 0; w < cache_pkg::WAYS; w++) begin
            ref_valid[w] = '0;
            ref_dirty[w] = '0;
        end
        @(posedge resetn);
        @(posedge clk);
        #1;
        test_reset_and_read();
        test_write_hit();
        test_write_miss();
        test_dirty_eviction();
        test_pipelined_reads();
        $display("Simulation finished: PASS");
        $finish;
    end

    initial begin
        #(NUM_TESTS * 400 * CYCLE_NS);
        $display("watchdog expired before the tests completed");
        stop_run();
    end

endmodule

/* bench/tb_clock.sv */
`timescale 1ns/1ps

module tb_clock (
    output logic clk,
    output logic resetn
);

    localparam int HALF_PERIOD = 20;   // 40 ns clock

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    initial begin
        resetn = 1'b0;
        repeat (4) @(posedge clk);
        #1 resetn = 1'b1;
    end

endmodule

/* build.f */
src/cache_pkg.sv
src/tag_store.sv
src/data_store.sv
src/write_buffer.sv
src/cache_ctrl.sv
src/cache.sv
bench/tb_clock.sv
bench/axi_mem_model.sv
bench/cache_tb.sv

/* src/cache.sv */
`timescale 1ns/1ps

module cache (
    input  logic                           clk,
    input  logic                           resetn,
    input  logic                           valid,
    input  logic                           op,      // 0 read, 1 write
    input  logic [cache_pkg::INDEX_W-1:0]  index,
    input  logic [cache_pkg::TAG_W-1:0]    tag,
    input  logic [cache_pkg::OFFSET_W-1:0] offset,
    input  logic [cache_pkg::STRB_W-1:0]   wstrb,
    input  logic [cache_pkg::WORD_W-1:0]   wdata,
    output logic                           addr_ok,
    output logic                           data_ok,
    output logic [cache_pkg::WORD_W-1:0]   rdata,
    output logic                           rd_req,
    output logic [2:0]                     rd_type,
    output logic [31:0]                    rd_addr,
    input  logic                           rd_rdy,
    input  logic                           ret_valid,
    input  logic                           ret_last,
    input  logic [cache_pkg::WORD_W-1:0]   ret_data,
    output logic                           wr_req,
    output logic [2:0]                     wr_type,
    output logic [31:0]                    wr_addr,
    output logic [cache_pkg::STRB_W-1:0]   wr_wstrb,
    output logic [cache_pkg::LINE_W-1:0]   wr_data,
    input  logic                           wr_rdy
);

    logic                          rd_en, hit, hit_way, victim_way, victim_dirty;
    logic [cache_pkg::TAG_W-1:0]   victim_tag, req_tag;
    logic [cache_pkg::INDEX_W-1:0] req_index, buf_index;
    logic [cache_pkg::BANK_W-1:0]  req_bank, fill_bank, buf_bank;
    logic [cache_pkg::STRB_W-1:0]  req_strb, buf_strb;
    logic [cache_pkg::WORD_W-1:0]  req_wdata, fill_data, buf_data, load_word;
    logic                          store_hit, lru_touch, fill_en, fill_way;
    logic                          fill_tag_en, fill_dirty, buf_busy, buf_way;

    assign rd_type  = cache_pkg::AXI_LINE_TYPE;
    assign wr_type  = cache_pkg::AXI_LINE_TYPE;
    assign wr_wstrb = cache_pkg::AXI_FULL_STRB;

    cache_ctrl u_ctrl (
        .clk, .resetn, .valid, .op, .index, .tag, .offset, .wstrb, .wdata,
        .rd_rdy, .ret_valid, .ret_last, .ret_data, .wr_rdy,
        .hit, .hit_way, .victim_way, .victim_dirty, .victim_tag, .load_word, .buf_busy,
        .addr_ok, .data_ok, .rdata, .rd_req, .rd_addr, .wr_req, .wr_addr,
        .rd_en, .req_index, .req_tag, .req_bank, .store_hit, .req_strb, .req_wdata,
        .lru_touch, .fill_en, .fill_bank, .fill_data, .fill_way, .fill_tag_en, .fill_dirty
    );

    tag_store u_tags (
        .clk, .resetn, .rd_en,
        .rd_index        (index),
        .cmp_tag         (req_tag),
        .lru_touch,
        .touch_way       (hit_way),
        .fill_en         (fill_tag_en),
        .fill_index      (req_index),
        .fill_way,
        .fill_tag        (req_tag),
        .fill_dirty,
        .dirty_set_en    (buf_busy),
        .dirty_set_way   (buf_way),
        .dirty_set_index (buf_index),
        .hit, .hit_way, .victim_way, .victim_dirty, .victim_tag
    );

    data_store u_data (
        .clk, .rd_en,
        .rd_index    (index),
        .sel_bank    (req_bank),
        .hit_way, .victim_way,
        .fill_en,
        .fill_index  (req_index),
        .fill_way, .fill_bank, .fill_data,
        .buf_en      (buf_busy),
        .buf_index, .buf_way, .buf_bank, .buf_strb, .buf_data,
        .load_word,
        .victim_line (wr_data)
    );

    write_buffer u_wbuf (
        .clk, .resetn, .store_hit,
        .store_way   (hit_way),
        .store_index (req_index),
        .store_bank  (req_bank),
        .store_strb  (req_strb),
        .store_data  (req_wdata),
        .busy        (buf_busy),
        .buf_index, .buf_way, .buf_bank, .buf_strb, .buf_data
    );

endmodule

/* src/cache_ctrl.sv */
`timescale 1ns/1ps

module cache_ctrl (
    input  logic                           clk,
    input  logic                           resetn,
    input  logic                           valid,
    input  logic                           op,
    input  logic [cache_pkg::INDEX_W-1:0]  index,
    input  logic [cache_pkg::TAG_W-1:0]    tag,
    input  logic [cache_pkg::OFFSET_W-1:0] offset,
    input  logic [cache_pkg::STRB_W-1:0]   wstrb,
    input  logic [cache_pkg::WORD_W-1:0]   wdata,
    input  logic                           rd_rdy,
    input  logic                           ret_valid,
    input  logic                           ret_last,
    input  logic [cache_pkg::WORD_W-1:0]   ret_data,
    input  logic                           wr_rdy,
    input  logic                           hit,
    input  logic                           hit_way,
    input  logic                           victim_way,
    input  logic                           victim_dirty,
    input  logic [cache_pkg::TAG_W-1:0]    victim_tag,
    input  logic [cache_pkg::WORD_W-1:0]   load_word,
    input  logic                           buf_busy,
    output logic                           addr_ok,
    output logic                           data_ok,
    output logic [cache_pkg::WORD_W-1:0]   rdata,
    output logic                           rd_req,
    output logic [31:0]                    rd_addr,
    output logic                           wr_req,
    output logic [31:0]                    wr_addr,
    output logic                           rd_en,
    output logic [cache_pkg::INDEX_W-1:0]  req_index,
    output logic [cache_pkg::TAG_W-1:0]    req_tag,
    output logic [cache_pkg::BANK_W-1:0]   req_bank,
    output logic                           store_hit,
    output logic [cache_pkg::STRB_W-1:0]   req_strb,
    output logic [cache_pkg::WORD_W-1:0]   req_wdata,
    output logic                           lru_touch,
    output logic                           fill_en,
    output logic [cache_pkg::BANK_W-1:0]   fill_bank,
    output logic [cache_pkg::WORD_W-1:0]   fill_data,
    output logic                           fill_way,
    output logic                           fill_tag_en,
    output logic                           fill_dirty
);

    cache_pkg::cache_state_e state, state_next;

    logic                          req_op;
    logic                          in_lookup;
    logic                          bank_beat;  // refill beat for the request's word
    logic [cache_pkg::WORD_W-1:0]  merged;

    assign in_lookup = (state == cache_pkg::LOOKUP);

    // no new request while a store hit is looked up or written
    assign addr_ok = (state == cache_pkg::IDLE && !buf_busy) || (in_lookup && hit && !req_op);
    assign rd_en   = valid && addr_ok;

    always_comb begin
        case (state)
            cache_pkg::IDLE:    state_next = rd_en ? cache_pkg::LOOKUP : cache_pkg::IDLE;
            cache_pkg::LOOKUP:  state_next = !hit  ? cache_pkg::MISS
                                           : rd_en ? cache_pkg::LOOKUP : cache_pkg::IDLE;
            cache_pkg::MISS:    state_next = (!victim_dirty || wr_rdy) ? cache_pkg::REPLACE
                                                                       : cache_pkg::MISS;
            cache_pkg::REPLACE: state_next = rd_rdy ? cache_pkg::REFILL : cache_pkg::REPLACE;
            cache_pkg::REFILL:  state_next = (ret_valid && ret_last) ? cache_pkg::IDLE
                                                                     : cache_pkg::REFILL;
            default:            state_next = cache_pkg::IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!resetn)
            state <= cache_pkg::IDLE;
        else
            state <= state_next;
    end

    always_ff @(posedge clk) begin
        if (rd_en) begin
            req_op    <= op;
            req_index <= index;
            req_tag   <= tag;
            req_bank  <= offset[cache_pkg::OFFSET_W-1 -: cache_pkg::BANK_W];
            req_strb  <= wstrb;
            req_wdata <= wdata;
        end
        if (in_lookup && !hit)
            fill_way <= victim_way;   // held until the refill ends
    end

    // beat counter, words arrive in bank order
    always_ff @(posedge clk) begin
        if (!resetn)
            fill_bank <= '0;
        else if (fill_en)
            fill_bank <= ret_last ? '0 : fill_bank + 1'b1;
    end

    assign fill_en     = (state == cache_pkg::REFILL) && ret_valid;
    assign fill_tag_en = fill_en && ret_last;
    assign fill_dirty  = req_op;
    assign bank_beat   = fill_en && (fill_bank == req_bank);

    always_comb begin
        for (int k = 0; k < cache_pkg::STRB_W; k++)
            merged[8*k +: 8] = req_strb[k] ? req_wdata[8*k +: 8] : ret_data[8*k +: 8];
    end

    assign fill_data = (bank_beat && req_op) ? merged : ret_data;

    assign store_hit = in_lookup && hit && req_op;
    assign lru_touch = in_lookup && hit;

    assign data_ok = (in_lookup && (hit || req_op)) || (bank_beat && !req_op);
    assign rdata   = (state == cache_pkg::REFILL) ? ret_data : load_word;

    assign rd_req  = (state == cache_pkg::REPLACE);
    assign rd_addr = {req_tag, req_index, {cache_pkg::OFFSET_W{1'b0}}};
    assign wr_req  = (state == cache_pkg::MISS) && victim_dirty;
    assign wr_addr = {victim_tag, req_index, {cache_pkg::OFFSET_W{1'b0}}};

endmodule

/* src/cache_pkg.sv */
package cache_pkg;

    // geometry
    localparam int SETS     = 256;
    localparam int INDEX_W  = 8;
    localparam int TAG_W    = 20;
    localparam int OFFSET_W = 4;
    localparam int WORDS    = 4;
    localparam int BANK_W   = 2;   // offset[3:2]
    localparam int WORD_W   = 32;
    localparam int STRB_W   = 4;
    localparam int LINE_W   = 128;
    localparam int WAYS     = 2;

    // line-port constants
    localparam logic [2:0]        AXI_LINE_TYPE = 3'd4;   // whole line
    localparam logic [STRB_W-1:0] AXI_FULL_STRB = 4'b1111;

    // main FSM, one-hot
    typedef enum logic [4:0] {
        IDLE    = 5'b00001,
        LOOKUP  = 5'b00010,
        MISS    = 5'b00100,
        REPLACE = 5'b01000,
        REFILL  = 5'b10000
    } cache_state_e;

    typedef enum logic {
        WBUF_IDLE  = 1'b0,
        WBUF_WRITE = 1'b1
    } wbuf_state_e;

endpackage

/* src/data_store.sv */
`timescale 1ns/1ps

module data_store (
    input  logic                          clk,
    input  logic                          rd_en,
    input  logic [cache_pkg::INDEX_W-1:0] rd_index,
    input  logic [cache_pkg::BANK_W-1:0]  sel_bank,
    input  logic                          hit_way,
    input  logic                          victim_way,
    input  logic                          fill_en,
    input  logic [cache_pkg::INDEX_W-1:0] fill_index,
    input  logic                          fill_way,
    input  logic [cache_pkg::BANK_W-1:0]  fill_bank,
    input  logic [cache_pkg::WORD_W-1:0]  fill_data,
    input  logic                          buf_en,
    input  logic [cache_pkg::INDEX_W-1:0] buf_index,
    input  logic                          buf_way,
    input  logic [cache_pkg::BANK_W-1:0]  buf_bank,
    input  logic [cache_pkg::STRB_W-1:0]  buf_strb,
    input  logic [cache_pkg::WORD_W-1:0]  buf_data,
    output logic [cache_pkg::WORD_W-1:0]  load_word,
    output logic [cache_pkg::LINE_W-1:0]  victim_line
);

    logic [cache_pkg::LINE_W-1:0] way_line [cache_pkg::WAYS];

    for (genvar w = 0; w < cache_pkg::WAYS; w++) begin : g_way
        for (genvar b = 0; b < cache_pkg::WORDS; b++) begin : g_bank
            logic [cache_pkg::WORD_W-1:0] mem [cache_pkg::SETS];
            logic [cache_pkg::WORD_W-1:0] rd_q;
            logic                         fill_sel;
            logic                         buf_sel;

            assign fill_sel = fill_en && (int'(fill_way) == w) && (int'(fill_bank) == b);
            assign buf_sel  = buf_en && (int'(buf_way) == w) && (int'(buf_bank) == b);

            always_ff @(posedge clk) begin
                if (fill_sel) begin
                    mem[fill_index] <= fill_data;   // refill writes the whole word
                end else if (buf_sel) begin
                    for (int k = 0; k < cache_pkg::STRB_W; k++)
                        if (buf_strb[k])
                            mem[buf_index][8*k +: 8] <= buf_data[8*k +: 8];
                end
                if (rd_en)
                    rd_q <= mem[rd_index];
            end

            assign way_line[w][b*cache_pkg::WORD_W +: cache_pkg::WORD_W] = rd_q;
        end
    end

    assign load_word   = way_line[hit_way][sel_bank*cache_pkg::WORD_W +: cache_pkg::WORD_W];
    assign victim_line = way_line[victim_way];   // word 0 in the low bits

endmodule

/* src/tag_store.sv */
`timescale 1ns/1ps

module tag_store (
    input  logic                          clk,
    input  logic                          resetn,
    input  logic                          rd_en,
    input  logic [cache_pkg::INDEX_W-1:0] rd_index,
    input  logic [cache_pkg::TAG_W-1:0]   cmp_tag,
    input  logic                          lru_touch,
    input  logic                          touch_way,
    input  logic                          fill_en,
    input  logic [cache_pkg::INDEX_W-1:0] fill_index,
    input  logic                          fill_way,
    input  logic [cache_pkg::TAG_W-1:0]   fill_tag,
    input  logic                          fill_dirty,
    input  logic                          dirty_set_en,
    input  logic                          dirty_set_way,
    input  logic [cache_pkg::INDEX_W-1:0] dirty_set_index,
    output logic                          hit,
    output logic                          hit_way,
    output logic                          victim_way,
    output logic                          victim_dirty,
    output logic [cache_pkg::TAG_W-1:0]   victim_tag
);

    logic [cache_pkg::TAG_W-1:0]   tag_mem [cache_pkg::WAYS][cache_pkg::SETS];
    logic [cache_pkg::SETS-1:0]    valid   [cache_pkg::WAYS];
    logic [cache_pkg::SETS-1:0]    dirty   [cache_pkg::WAYS];
    logic [cache_pkg::SETS-1:0]    lru;     // way used last, per set
    logic [cache_pkg::TAG_W-1:0]   tag_q   [cache_pkg::WAYS];
    logic [cache_pkg::WAYS-1:0]    valid_q;
    logic [cache_pkg::INDEX_W-1:0] idx_q;   // set of the request in LOOKUP
    logic [cache_pkg::WAYS-1:0]    way_hit;

    // tag ram, synchronous read
    always_ff @(posedge clk) begin
        if (fill_en)
            tag_mem[fill_way][fill_index] <= fill_tag;
        if (rd_en) begin
            for (int w = 0; w < cache_pkg::WAYS; w++) begin
                tag_q[w]   <= tag_mem[w][rd_index];
                valid_q[w] <= valid[w][rd_index];
            end
            idx_q <= rd_index;
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            for (int w = 0; w < cache_pkg::WAYS; w++) begin
                valid[w] <= '0;
                dirty[w] <= '0;
            end
            lru <= '0;
        end else begin
            if (fill_en) begin
                valid[fill_way][fill_index] <= 1'b1;
                dirty[fill_way][fill_index] <= fill_dirty;
                lru[fill_index]             <= fill_way;
            end else if (dirty_set_en) begin
                dirty[dirty_set_way][dirty_set_index] <= 1'b1;
            end
            if (lru_touch)
                lru[idx_q] <= touch_way;
        end
    end

    always_comb begin
        for (int w = 0; w < cache_pkg::WAYS; w++)
            way_hit[w] = valid_q[w] && (tag_q[w] == cmp_tag);
    end

    assign hit     = |way_hit;
    assign hit_way = way_hit[1];

    // free way first, else the one not used last
    always_comb begin
        if (!valid_q[0])
            victim_way = 1'b0;
        else if (!valid_q[1])
            victim_way = 1'b1;
        else
            victim_way = ~lru[idx_q];
    end

    assign victim_dirty = valid_q[victim_way] && dirty[victim_way][idx_q];
    assign victim_tag   = tag_q[victim_way];

endmodule

/* src/write_buffer.sv */
`timescale 1ns/1ps

module write_buffer (
    input  logic                          clk,
    input  logic                          resetn,
    input  logic                          store_hit,
    input  logic                          store_way,
    input  logic [cache_pkg::INDEX_W-1:0] store_index,
    input  logic [cache_pkg::BANK_W-1:0]  store_bank,
    input  logic [cache_pkg::STRB_W-1:0]  store_strb,
    input  logic [cache_pkg::WORD_W-1:0]  store_data,
    output logic                          busy,
    output logic [cache_pkg::INDEX_W-1:0] buf_index,
    output logic                          buf_way,
    output logic [cache_pkg::BANK_W-1:0]  buf_bank,
    output logic [cache_pkg::STRB_W-1:0]  buf_strb,
    output logic [cache_pkg::WORD_W-1:0]  buf_data
);

    cache_pkg::wbuf_state_e state, state_next;

    always_comb begin
        case (state)
            cache_pkg::WBUF_IDLE: state_next = store_hit ? cache_pkg::WBUF_WRITE
                                                         : cache_pkg::WBUF_IDLE;
            default:              state_next = cache_pkg::WBUF_IDLE;   // single write cycle
        endcase
    end

    always_ff @(posedge clk) begin
        if (!resetn)
            state <= cache_pkg::WBUF_IDLE;
        else
            state <= state_next;
    end

    always_ff @(posedge clk) begin
        if (store_hit) begin
            buf_way   <= store_way;
            buf_index <= store_index;
            buf_bank  <= store_bank;
            buf_strb  <= store_strb;
            buf_data  <= store_data;
        end
    end

    assign busy = (state == cache_pkg::WBUF_WRITE);

endmodule
